/* Bender.yml */
package:
  name: hazard_unit

sources:
  - files:
      - hw/mipsIsaPkg.sv
      - hw/hazardPkg.sv
      - hw/instrClassifier.sv
      - hw/stageTracker.sv
      - hw/stallDetect.sv
      - hw/bypassSelect.sv
      - hw/hazardUnit.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/hazardUnitTb.sv

/* compile.f */
+incdir+test
hw/mipsIsaPkg.sv
hw/hazardPkg.sv
hw/instrClassifier.sv
hw/stageTracker.sv
hw/stallDetect.sv
hw/bypassSelect.sv
hw/hazardUnit.sv
test/hazardUnitTb.sv

/* hw/bypassSelect.sv */
`default_nettype none

module bypassSelect (
	input  mipsIsaPkg::stageRecT fdRec_i,
	input  mipsIsaPkg::stageRecT deRec_i,
	input  mipsIsaPkg::stageRecT emRec_i,
	input  mipsIsaPkg::stageRecT mwRec_i,
	output hazardPkg::dBypassT   drs_o,
	output hazardPkg::dBypassT   drt_o,
	output hazardPkg::eBypassT   ers_o,
	output hazardPkg::eBypassT   ert_o,
	output hazardPkg::mBypassT   mrt_o
);
	import mipsIsaPkg::*;
	import hazardPkg::*;

	logic deReadsRs;
	logic deReadsRt;

	// Earlier stages hold the newer value, so they win
	function automatic dBypassT decodeSel(regAddrT src, stageRecT de, stageRecT em);
		if (isLink(de.cls) && writesReg(de, src))
			return dDeLink;
		if (isLink(em.cls) && writesReg(em, src))
			return dEmLink;
		if (isAlu(em.cls) && writesReg(em, src))
			return dEmAlu;
		if (em.cls.mf && writesReg(em, src))
			return dEmMf;
		return dNone;
	endfunction

	function automatic eBypassT executeSel(regAddrT src, stageRecT em, stageRecT mw);
		if (isLink(em.cls) && writesReg(em, src))
			return eEmLink;
		if (isAlu(em.cls) && writesReg(em, src))
			return eEmAlu;
		if (em.cls.mf && writesReg(em, src))
			return eEmMf;
		if (isLink(mw.cls) && writesReg(mw, src))
			return eMwLink;
		if (isAlu(mw.cls) && writesReg(mw, src))
			return eMwAlu;
		if (mw.cls.mf && writesReg(mw, src))
			return eMwMf;
		if (mw.cls.load && writesReg(mw, src))
			return eMwLoad;
		return eNone;
	endfunction

	assign deReadsRs = isAlu(deRec_i.cls) || deRec_i.cls.md || deRec_i.cls.mt ||
		deRec_i.cls.load || deRec_i.cls.store;
	assign deReadsRt = deRec_i.cls.calR || deRec_i.cls.md || deRec_i.cls.store;

	assign drs_o = (fdRec_i.cls.branch || fdRec_i.cls.jr || fdRec_i.cls.jalr) ?
		decodeSel(fdRec_i.rs, deRec_i, emRec_i) : dNone;
	assign drt_o = fdRec_i.cls.branch ? decodeSel(fdRec_i.rt, deRec_i, emRec_i) : dNone;

	assign ers_o = deReadsRs ? executeSel(deRec_i.rs, emRec_i, mwRec_i) : eNone;
	assign ert_o = deReadsRt ? executeSel(deRec_i.rt, emRec_i, mwRec_i) : eNone;

	// Store data read in memory may still be in flight from a load one stage ahead
	assign mrt_o = (emRec_i.cls.store && mwRec_i.cls.load && writesReg(mwRec_i, emRec_i.rt)) ?
		mMwLoad : mNone;

endmodule

`default_nettype wire

/* hw/hazardPkg.sv */
`default_nettype none

package hazardPkg;

	// Forwarding sources for the branch and jump compare in decode
	typedef enum logic [2:0] {
		dNone,
		dDeLink,
		dEmLink,
		dEmAlu,
		dEmMf
	} dBypassT;

	// Forwarding sources for the ALU operands in execute
	typedef enum logic [3:0] {
		eNone,
		eEmLink,
		eEmAlu,
		eEmMf,
		eMwLink,
		eMwAlu,
		eMwMf,
		eMwLoad
	} eBypassT;

	// Store data in memory can only come from a load in writeback
	typedef enum logic {
		mNone,
		mMwLoad
	} mBypassT;

	typedef struct packed {
		logic    stall;
		dBypassT drs;
		dBypassT drt;
		eBypassT ers;
		eBypassT ert;
		mBypassT mrt;
	} hazardOutT;

endpackage

`default_nettype wire

/* hw/hazardUnit.sv */
`default_nettype none

module hazardUnit (
	input  logic                 clk_i,
	input  logic                 rstN_i,
	input  mipsIsaPkg::instrT    instr_i,
	input  logic                 instrValid_i,
	input  logic                 eBusy_i,
	output hazardPkg::hazardOutT hazard_o
);
	import mipsIsaPkg::*;
	import hazardPkg::*;

	stageRecT fetchRec;
	stageRecT fdRec;
	stageRecT deRec;
	stageRecT emRec;
	stageRecT mwRec;
	logic     stall;
	dBypassT  drs;
	dBypassT  drt;
	eBypassT  ers;
	eBypassT  ert;
	mBypassT  mrt;

	instrClassifier classifier (
		.instr_i (instr_i),
		.valid_i (instrValid_i),
		.rec_o   (fetchRec)
	);

	stageTracker tracker (
		.clk_i      (clk_i),
		.rstN_i     (rstN_i),
		.fetchRec_i (fetchRec),
		.stall_i    (stall),
		.fdRec_o    (fdRec),
		.deRec_o    (deRec),
		.emRec_o    (emRec),
		.mwRec_o    (mwRec)
	);

	stallDetect stallCheck (
		.fdRec_i (fdRec),
		.deRec_i (deRec),
		.emRec_i (emRec),
		.eBusy_i (eBusy_i),
		.stall_o (stall)
	);

	bypassSelect bypass (
		.fdRec_i (fdRec),
		.deRec_i (deRec),
		.emRec_i (emRec),
		.mwRec_i (mwRec),
		.drs_o   (drs),
		.drt_o   (drt),
		.ers_o   (ers),
		.ert_o   (ert),
		.mrt_o   (mrt)
	);

	assign hazard_o = '{stall: stall, drs: drs, drt: drt, ers: ers, ert: ert, mrt: mrt};

endmodule

`default_nettype wire

/* hw/instrClassifier.sv */
`default_nettype none

module instrClassifier (
	input  mipsIsaPkg::instrT    instr_i,
	input  logic                 valid_i,
	output mipsIsaPkg::stageRecT rec_o
);
	import mipsIsaPkg::*;

	opcodeT     opcode;
	functT      funct;
	regAddrT    rs;
	regAddrT    rt;
	regAddrT    rd;
	regAddrT    srcRt;
	regAddrT    dst;
	instrClassT cls;

	assign opcode = instr_i[31:26];
	assign rs     = instr_i[25:21];
	assign rt     = instr_i[20:16];
	assign rd     = instr_i[15:11];
	assign funct  = instr_i[5:0];

	// Under opRegImm the rt field is a sub-opcode, not a source register
	assign srcRt = (opcode == opRegImm) ? '0 : rt;

	always_comb begin
		cls = '0;
		case (opcode)
			opRType: begin
				case (funct)
					functSll, functSrl, functSra, functSllv, functSrlv, functSrav,
					functAdd, functAddu, functSub, functSubu, functAnd, functOr,
					functXor, functNor, functSlt, functSltu:
						cls.calR = 1'b1;
					functMult, functMultu, functDiv, functDivu:
						cls.md = 1'b1;
					functMthi, functMtlo:
						cls.mt = 1'b1;
					functMfhi, functMflo:
						cls.mf = 1'b1;
					functJr:
						cls.jr = 1'b1;
					functJalr:
						cls.jalr = 1'b1;
					default: ;
				endcase
			end
			opRegImm:
				cls.branch = (rt == rtBltz) || (rt == rtBgez);
			opBeq, opBne, opBlez, opBgtz:
				cls.branch = 1'b1;
			opJal:
				cls.jal = 1'b1;
			opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui:
				cls.calI = 1'b1;
			opLb, opLh, opLw, opLbu, opLhu:
				cls.load = 1'b1;
			opSb, opSh, opSw:
				cls.store = 1'b1;
			default: ;
		endcase
	end

	always_comb begin
		if (cls.calR || cls.mf || cls.jalr)
			dst = rd;
		else if (cls.calI || cls.load)
			dst = rt;
		else if (cls.jal)
			dst = linkReg;
		else
			dst = '0;
	end

	always_comb begin
		rec_o = recBubble;
		if (valid_i) begin
			rec_o.cls      = cls;
			rec_o.rs       = rs;
			rec_o.rt       = srcRt;
			rec_o.dst      = dst;
			// dst stays zero for classes that write nothing
			rec_o.regWrite = (dst != '0);
		end
	end

endmodule

`default_nettype wire

/* hw/mipsIsaPkg.sv */
`default_nettype none

package mipsIsaPkg;

	typedef logic [31:0] instrT;
	typedef logic [4:0]  regAddrT;
	typedef logic [5:0]  opcodeT;
	typedef logic [5:0]  functT;

	localparam opcodeT opRType  = 6'h00;
	localparam opcodeT opRegImm = 6'h01;
	localparam opcodeT opJal    = 6'h03;
	localparam opcodeT opBeq    = 6'h04;
	localparam opcodeT opBne    = 6'h05;
	localparam opcodeT opBlez   = 6'h06;
	localparam opcodeT opBgtz   = 6'h07;
	localparam opcodeT opAddi   = 6'h08;
	localparam opcodeT opAddiu  = 6'h09;
	localparam opcodeT opSlti   = 6'h0a;
	localparam opcodeT opSltiu  = 6'h0b;
	localparam opcodeT opAndi   = 6'h0c;
	localparam opcodeT opOri    = 6'h0d;
	localparam opcodeT opXori   = 6'h0e;
	localparam opcodeT opLui    = 6'h0f;
	localparam opcodeT opLb     = 6'h20;
	localparam opcodeT opLh     = 6'h21;
	localparam opcodeT opLw     = 6'h23;
	localparam opcodeT opLbu    = 6'h24;
	localparam opcodeT opLhu    = 6'h25;
	localparam opcodeT opSb     = 6'h28;
	localparam opcodeT opSh     = 6'h29;
	localparam opcodeT opSw     = 6'h2b;

	localparam functT functSll   = 6'h00;
	localparam functT functSrl   = 6'h02;
	localparam functT functSra   = 6'h03;
	localparam functT functSllv  = 6'h04;
	localparam functT functSrlv  = 6'h06;
	localparam functT functSrav  = 6'h07;
	localparam functT functJr    = 6'h08;
	localparam functT functJalr  = 6'h09;
	localparam functT functMfhi  = 6'h10;
	localparam functT functMthi  = 6'h11;
	localparam functT functMflo  = 6'h12;
	localparam functT functMtlo  = 6'h13;
	localparam functT functMult  = 6'h18;
	localparam functT functMultu = 6'h19;
	localparam functT functDiv   = 6'h1a;
	localparam functT functDivu  = 6'h1b;
	localparam functT functAdd   = 6'h20;
	localparam functT functAddu  = 6'h21;
	localparam functT functSub   = 6'h22;
	localparam functT functSubu  = 6'h23;
	localparam functT functAnd   = 6'h24;
	localparam functT functOr    = 6'h25;
	localparam functT functXor   = 6'h26;
	localparam functT functNor   = 6'h27;
	localparam functT functSlt   = 6'h2a;
	localparam functT functSltu  = 6'h2b;

	// The rt field selects between bltz and bgez under opRegImm
	localparam regAddrT rtBltz = 5'd0;
	localparam regAddrT rtBgez = 5'd1;

	localparam regAddrT linkReg = 5'd31;

	typedef struct packed {
		logic calR;
		logic calI;
		logic md;
		logic mt;
		logic mf;
		logic load;
		logic store;
		logic branch;
		logic jr;
		logic jal;
		logic jalr;
	} instrClassT;

	typedef struct packed {
		instrClassT cls;
		regAddrT    rs;
		regAddrT    rt;
		regAddrT    dst;
		logic       regWrite;
	} stageRecT;

	localparam stageRecT recBubble = '0;

	function automatic logic isAlu(instrClassT cls);
		return cls.calR || cls.calI;
	endfunction

	function automatic logic isLink(instrClassT cls);
		return cls.jal || cls.jalr;
	endfunction

	// True when the producer record writes a nonzero register that the consumer reads
	function automatic logic writesReg(stageRecT producer, regAddrT src);
		return producer.regWrite && (producer.dst == src) && (src != '0);
	endfunction

endpackage

`default_nettype wire

/* hw/stageTracker.sv */
`default_nettype none

module stageTracker (
	input  logic                 clk_i,
	input  logic                 rstN_i,
	input  mipsIsaPkg::stageRecT fetchRec_i,
	input  logic                 stall_i,
	output mipsIsaPkg::stageRecT fdRec_o,
	output mipsIsaPkg::stageRecT deRec_o,
	output mipsIsaPkg::stageRecT emRec_o,
	output mipsIsaPkg::stageRecT mwRec_o
);
	import mipsIsaPkg::*;

	// Fetch and decode freeze on a stall while execute takes a bubble
	always_ff @(posedge clk_i or negedge rstN_i) begin
		if (!rstN_i) begin
			fdRec_o <= recBubble;
			deRec_o <= recBubble;
		end else if (stall_i) begin
			deRec_o <= recBubble;
		end else begin
			fdRec_o <= fetchRec_i;
			deRec_o <= fdRec_o;
		end
	end

	// The back half of the pipe never waits
	always_ff @(posedge clk_i or negedge rstN_i) begin
		if (!rstN_i) begin
			emRec_o <= recBubble;
			mwRec_o <= recBubble;
		end else begin
			emRec_o <= deRec_o;
			mwRec_o <= emRec_o;
		end
	end

endmodule

`default_nettype wire

/* hw/stallDetect.sv */
`default_nettype none

module stallDetect (
	input  mipsIsaPkg::stageRecT fdRec_i,
	input  mipsIsaPkg::stageRecT deRec_i,
	input  mipsIsaPkg::stageRecT emRec_i,
	input  logic                 eBusy_i,
	output logic                 stall_o
);
	import mipsIsaPkg::*;

	logic readsRsInD;
	logic readsRsInE;
	logic readsRtInE;
	logic deProducer;
	logic stallRs;
	logic stallRt;
	logic stallMd;

	// Branches and register jumps resolve in decode and need their operands early
	assign readsRsInD = fdRec_i.cls.branch || fdRec_i.cls.jr || fdRec_i.cls.jalr;
	assign readsRsInE = isAlu(fdRec_i.cls) || fdRec_i.cls.md || fdRec_i.cls.mt ||
		fdRec_i.cls.load || fdRec_i.cls.store;
	assign readsRtInE = fdRec_i.cls.calR || fdRec_i.cls.md;

	// A link result is already known in DE and gets forwarded instead
	assign deProducer = isAlu(deRec_i.cls) || deRec_i.cls.mf || deRec_i.cls.load;

	assign stallRs =
		(readsRsInD && deProducer && writesReg(deRec_i, fdRec_i.rs)) ||
		(readsRsInD && emRec_i.cls.load && writesReg(emRec_i, fdRec_i.rs)) ||
		(readsRsInE && deRec_i.cls.load && writesReg(deRec_i, fdRec_i.rs));

	assign stallRt =
		(fdRec_i.cls.branch && deProducer && writesReg(deRec_i, fdRec_i.rt)) ||
		(fdRec_i.cls.branch && emRec_i.cls.load && writesReg(emRec_i, fdRec_i.rt)) ||
		(readsRtInE && deRec_i.cls.load && writesReg(deRec_i, fdRec_i.rt));

	// HI/LO users wait until the multiply/divide unit is idle
	assign stallMd = (fdRec_i.cls.md || fdRec_i.cls.mt || fdRec_i.cls.mf) &&
		(deRec_i.cls.md || eBusy_i);

	assign stall_o = stallRs || stallRt || stallMd;

endmodule

`default_nettype wire

/* test/hazardChecks.svh */
`ifndef HAZARD_CHECKS_SVH
`define HAZARD_CHECKS_SVH

function automatic instrT rTypeWord(functT funct, regAddrT rs, regAddrT rt, regAddrT rd);
	return {opRType, rs, rt, rd, 5'd0, funct};
endfunction

function automatic instrT iTypeWord(opcodeT op, regAddrT rs, regAddrT rt, logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic instrT jTypeWord(opcodeT op, logic [25:0] target);
	return {op, target};
endfunction

task automatic compareStall(logic got, logic exp, string what);
	checkCount++;
	if (got !== exp) begin
		errorCount++;
		$display("MISMATCH at %0d ns: %s, stall is %b, expected %b", $time, what, got, exp);
	end
endtask

task automatic compareDBypass(dBypassT got, dBypassT exp, string what);
	checkCount++;
	if (got !== exp) begin
		errorCount++;
		$display("MISMATCH at %0d ns: %s, select is %s, expected %s",
			$time, what, got.name(), exp.name());
	end
endtask

task automatic compareEBypass(eBypassT got, eBypassT exp, string what);
	checkCount++;
	if (got !== exp) begin
		errorCount++;
		$display("MISMATCH at %0d ns: %s, select is %s, expected %s",
			$time, what, got.name(), exp.name());
	end
endtask

task automatic compareMBypass(mBypassT got, mBypassT exp, string what);
	checkCount++;
	if (got !== exp) begin
		errorCount++;
		$display("MISMATCH at %0d ns: %s, select is %s, expected %s",
			$time, what, got.name(), exp.name());
	end
endtask

task automatic compareCount(int got, int exp, string what);
	checkCount++;
	if (got != exp) begin
		errorCount++;
		$display("MISMATCH at %0d ns: %s, count is %0d, expected %0d", $time, what, got, exp);
	end
endtask

`endif

/* test/hazardUnitTb.sv */
`default_nettype none

module hazardUnitTb;
	timeunit 1ns;
	timeprecision 100ps;

	import mipsIsaPkg::*;
	import hazardPkg::*;

	localparam int clkPeriod   = 8;
	localparam int resetCycles = 16;
	localparam int busyHold    = 3;
	// The directed tests take roughly a hundred cycles including reset
	localparam int testCycles  = 84;
	localparam int cycleLimit  = 4 * (resetCycles + testCycles);

	logic      clk;
	logic      rstN;
	instrT     instr;
	logic      instrValid;
	logic      eBusy;
	hazardOutT hazard;

	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;

	`include "hazardChecks.svh"

	hazardUnit dut (
		.clk_i        (clk),
		.rstN_i       (rstN),
		.instr_i      (instr),
		.instrValid_i (instrValid),
		.eBusy_i      (eBusy),
		.hazard_o     (hazard)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// Inputs change on the rising edge and the outputs are sampled 1 ns before the next one
	task automatic driveCycle(instrT word, logic valid, logic busy);
		@(posedge clk);
		instr      <= word;
		instrValid <= valid;
		eBusy      <= busy;
		#(clkPeriod - 1);
	endtask

	task automatic idleCycle();
		driveCycle('0, 1'b0, 1'b0);
	endtask

	task automatic drainPipe();
		repeat (5) idleCycle();
	endtask

	task automatic holdUntilAccepted(instrT word, int limit, output int stalls);
		stalls = 0;
		driveCycle(word, 1'b1, 1'b0);
		while (hazard.stall === 1'b1 && stalls < limit) begin
			stalls++;
			driveCycle(word, 1'b1, 1'b0);
		end
		if (hazard.stall !== 1'b0) begin
			errorCount++;
			$display("Instruction %h was still not accepted after %0d stalled cycles",
				word, stalls);
		end
	endtask

	task automatic resetState();
		idleCycle();
		compareStall(hazard.stall, 1'b0, "after reset");
		compareDBypass(hazard.drs, dNone, "drs after reset");
		compareDBypass(hazard.drt, dNone, "drt after reset");
		compareEBypass(hazard.ers, eNone, "ers after reset");
		compareEBypass(hazard.ert, eNone, "ert after reset");
		compareMBypass(hazard.mrt, mNone, "mrt after reset");
	endtask

	task automatic loadUseStall();
		int stalls;
		driveCycle(iTypeWord(opLw, 5'd1, 5'd5, 16'h0010), 1'b1, 1'b0);
		compareStall(hazard.stall, 1'b0, "lw presented");
		driveCycle(rTypeWord(functAddu, 5'd5, 5'd1, 5'd6), 1'b1, 1'b0);
		compareStall(hazard.stall, 1'b0, "addu presented with lw in FD");
		// The ori behind the addu waits out the load-use bubble
		holdUntilAccepted(iTypeWord(opOri, 5'd0, 5'd9, 16'h0001), 8, stalls);
		compareCount(stalls, 1, "load-use stall cycles");
		idleCycle();
		compareStall(hazard.stall, 1'b0, "addu in DE");
		compareEBypass(hazard.ers, eMwLoad, "addu rs from lw in MW");
		compareEBypass(hazard.ert, eNone, "addu rt has no producer");
		drainPipe();
	endtask

	task automatic branchAfterAlu();
		int stalls;
		driveCycle(rTypeWord(functAddu, 5'd1, 5'd2, 5'd3), 1'b1, 1'b0);
		compareStall(hazard.stall, 1'b0, "addu presented");
		driveCycle(iTypeWord(opBeq, 5'd3, 5'd4, 16'h0008), 1'b1, 1'b0);
		compareStall(hazard.stall, 1'b0, "beq presented with addu in FD");
		holdUntilAccepted(iTypeWord(opOri, 5'd0, 5'd10, 16'h0002), 8, stalls);
		compareCount(stalls, 1, "branch stall cycles behind addu");
		// Sampled in the cycle where beq sits in FD and addu in EM
		compareDBypass(hazard.drs, dEmAlu, "beq rs from addu in EM");
		compareDBypass(hazard.drt, dNone, "beq rt has no producer");
		drainPipe();
	endtask

	task automatic linkForwarding();
		driveCycle(jTypeWord(opJal, 26'h0000040), 1'b1, 1'b0);
		compareStall(hazard.stall, 1'b0, "jal presented");
		driveCycle(rTypeWord(functJr, linkReg, 5'd0, 5'd0), 1'b1, 1'b0);
		compareStall(hazard.stall, 1'b0, "jr presented with jal in FD");
		idleCycle();
		compareStall(hazard.stall, 1'b0, "jr in FD behind jal");
		compareDBypass(hazard.drs, dDeLink, "jr rs from jal in DE");
		idleCycle();
		compareStall(hazard.stall, 1'b0, "jr moved on");
		drainPipe();
	endtask

	task automatic mulDivStall();
		int stalls;
		driveCycle(rTypeWord(functMult, 5'd1, 5'd2, 5'd0), 1'b1, 1'b0);
		compareStall(hazard.stall, 1'b0, "mult presented");
		driveCycle(rTypeWord(functMfhi, 5'd0, 5'd0, 5'd8), 1'b1, 1'b0);
		compareStall(hazard.stall, 1'b0, "mfhi presented with mult in FD");
		holdUntilAccepted(iTypeWord(opOri, 5'd0, 5'd11, 16'h0003), 8, stalls);
		compareCount(stalls, 1, "mfhi stall cycles behind mult");
		drainPipe();

		driveCycle(rTypeWord(functMfhi, 5'd0, 5'd0, 5'd9), 1'b1, 1'b1);
		compareStall(hazard.stall, 1'b0, "busy with no HI/LO user in FD");
		for (int i = 0; i < busyHold; i++) begin
			driveCycle(iTypeWord(opOri, 5'd0, 5'd12, 16'h0004), 1'b1, 1'b1);
			compareStall(hazard.stall, 1'b1, "mfhi in FD while busy");
		end
		driveCycle(iTypeWord(opOri, 5'd0, 5'd12, 16'h0004), 1'b1, 1'b0);
		compareStall(hazard.stall, 1'b0, "mfhi released when busy drops");
		drainPipe();
	endtask

	task automatic zeroRegAndStore();
		driveCycle(rTypeWord(functAddu, 5'd1, 5'd2, 5'd0), 1'b1, 1'b0);
		driveCycle(iTypeWord(opLw, 5'd1, 5'd0, 16'h0020), 1'b1, 1'b0);
		driveCycle(rTypeWord(functAddu, 5'd0, 5'd0, 5'd6), 1'b1, 1'b0);
		idleCycle();
		compareStall(hazard.stall, 1'b0, "addu reading r0 behind lw r0");
		idleCycle();
		compareEBypass(hazard.ers, eNone, "rs of r0 never forwards");
		compareEBypass(hazard.ert, eNone, "rt of r0 never forwards");
		drainPipe();

		// One r0 producer sits in DE and the other in EM when beq reaches FD
		driveCycle(rTypeWord(functAddu, 5'd1, 5'd2, 5'd0), 1'b1, 1'b0);
		driveCycle(rTypeWord(functAddu, 5'd1, 5'd2, 5'd0), 1'b1, 1'b0);
		driveCycle(iTypeWord(opBeq, 5'd0, 5'd0, 16'h0004), 1'b1, 1'b0);
		idleCycle();
		compareStall(hazard.stall, 1'b0, "beq r0 behind addu writing r0");
		compareDBypass(hazard.drs, dNone, "beq rs of r0");
		compareDBypass(hazard.drt, dNone, "beq rt of r0");
		drainPipe();

		driveCycle(iTypeWord(opLw, 5'd1, 5'd7, 16'h0000), 1'b1, 1'b0);
		driveCycle(iTypeWord(opSw, 5'd2, 5'd7, 16'h0004), 1'b1, 1'b0);
		compareStall(hazard.stall, 1'b0, "sw presented with lw in FD");
		idleCycle();
		compareStall(hazard.stall, 1'b0, "sw in FD behind lw");
		idleCycle();
		compareEBypass(hazard.ert, eNone, "sw rt with lw in EM");
		compareMBypass(hazard.mrt, mNone, "sw in DE");
		idleCycle();
		compareMBypass(hazard.mrt, mMwLoad, "sw data from lw in MW");
		drainPipe();
	endtask

	initial begin
		instr      = '0;
		instrValid = 1'b0;
		eBusy      = 1'b0;
		rstN       = 1'b0;
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;

		resetState();
		loadUseStall();
		branchAfterAlu();
		linkForwarding();
		mulDivStall();
		zeroRegAndStore();

		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
